/* hdl/l2_cache_pkg.sv */
`default_nettype none

package l2_cache_pkg;

  // Address split and geometry.
  localparam int TAG_W    = 9;
  localparam int INDEX_W  = 3;
  localparam int OFFSET_W = 4;
  localparam int NUM_WAYS = 4;
  localparam int NUM_SETS = 8;
  localparam int LINE_W   = 8 * (1 << OFFSET_W);

  typedef logic [15:0]         lc3b_word;
  typedef logic [LINE_W-1:0]   l2_line_t;
  typedef logic [TAG_W-1:0]    l2_tag_t;
  typedef logic [INDEX_W-1:0]  l2_index_t;
  typedef logic [1:0]          l2_way_t;
  typedef logic [2:0]          l2_lru_t;

  typedef enum logic [1:0] {S_CHECK, S_WRITEBACK, S_ALLOCATE} l2_state_e;
  typedef enum logic {SRC_PMEM, SRC_CPU} l2_data_src_e;
  typedef enum logic {ADDR_REQUEST, ADDR_VICTIM} l2_addr_src_e;

  // Control to datapath.
  typedef struct packed {
    logic         way_write;
    logic         fill;
    l2_data_src_e data_src;
    logic         dirty_in;
    logic         lru_touch;
    l2_addr_src_e addr_src;
  } l2_ctrl_t;

  // Datapath to control.
  typedef struct packed {
    logic hit;
    logic victim_dirty;
  } l2_status_t;

endpackage : l2_cache_pkg

`default_nettype wire

/* hdl/l2_way_array.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_way_array
  import l2_cache_pkg::*;
#(
  parameter int WIDTH = 1
)
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  l2_index_t             index,
  input  wire logic             write,
  input  wire logic [WIDTH-1:0] datain,
  output logic      [WIDTH-1:0] dataout
);

  logic [WIDTH-1:0] entries [NUM_SETS];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_SETS; i++)
        entries[i] <= '0;
    end
    else if (write)
    begin
      entries[index] <= datain;
    end
  end

  // Read is combinational.
  assign dataout = entries[index];

endmodule : l2_way_array

`default_nettype wire

/* hdl/l2_plru.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_plru
  import l2_cache_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  l2_index_t index,
  input  wire logic touch,
  input  l2_way_t   touched_way,
  output l2_way_t   victim
);

  l2_lru_t lru_bits [NUM_SETS];
  l2_lru_t cur_bits;
  l2_lru_t next_bits;

  assign cur_bits = lru_bits[index];

  // Tree walk, b2 picks the pair.
  always_comb
  begin
    if (!cur_bits[2])
      victim = cur_bits[1] ? 2'd1 : 2'd0;
    else
      victim = cur_bits[0] ? 2'd3 : 2'd2;
  end

  always_comb
  begin
    next_bits = cur_bits;
    case (touched_way)
      2'd0:    begin next_bits[2] = 1'b1; next_bits[1] = 1'b1; end
      2'd1:    begin next_bits[2] = 1'b1; next_bits[1] = 1'b0; end
      2'd2:    begin next_bits[2] = 1'b0; next_bits[0] = 1'b1; end
      default: begin next_bits[2] = 1'b0; next_bits[0] = 1'b0; end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_SETS; i++)
        lru_bits[i] <= '0;
    end
    else if (touch)
    begin
      lru_bits[index] <= next_bits;
    end
  end

  // Hit way from the datapath must be resolved when recorded.
  a_touch_known : assert property (@(posedge clk) disable iff (!rst_n)
    touch |-> !$isunknown(touched_way));

endmodule : l2_plru

`default_nettype wire

/* hdl/l2_cache_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_cache_datapath
  import l2_cache_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  lc3b_word   mem_address,
  input  l2_line_t   mem_wdata,
  input  l2_line_t   pmem_rdata,
  input  l2_ctrl_t   ctrl,
  output l2_status_t status,
  output l2_line_t   mem_rdata,
  output l2_line_t   pmem_wdata,
  output lc3b_word   pmem_address
);

  l2_tag_t   req_tag;
  l2_index_t index;

  l2_line_t              data_out  [NUM_WAYS];
  l2_tag_t               tag_out   [NUM_WAYS];
  logic [NUM_WAYS-1:0]   valid_out;
  logic [NUM_WAYS-1:0]   dirty_out;
  logic [NUM_WAYS-1:0]   way_hit;
  logic [NUM_WAYS-1:0]   way_we;

  l2_way_t   hit_way;
  l2_way_t   victim;
  l2_way_t   write_way;
  l2_line_t  line_in;
  l2_tag_t   phys_tag;

  assign req_tag = mem_address[15 -: TAG_W];
  assign index   = mem_address[OFFSET_W +: INDEX_W];

  // *************************************************************************
  // Storage, one column of each kind per way.
  // *************************************************************************

  assign line_in   = (ctrl.data_src == SRC_CPU) ? mem_wdata : pmem_rdata;
  assign write_way = ctrl.fill ? victim : hit_way;

  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    assign way_we[w]  = ctrl.way_write && (write_way == l2_way_t'(w));
    assign way_hit[w] = valid_out[w] && (tag_out[w] == req_tag);

    l2_way_array #(.WIDTH(LINE_W)) u_data (
      .clk     (clk),
      .rst_n   (rst_n),
      .index   (index),
      .write   (way_we[w]),
      .datain  (line_in),
      .dataout (data_out[w])
    );

    l2_way_array #(.WIDTH(TAG_W)) u_tag (
      .clk     (clk),
      .rst_n   (rst_n),
      .index   (index),
      .write   (way_we[w]),
      .datain  (req_tag),
      .dataout (tag_out[w])
    );

    // Every write leaves the line valid.
    l2_way_array #(.WIDTH(1)) u_valid (
      .clk     (clk),
      .rst_n   (rst_n),
      .index   (index),
      .write   (way_we[w]),
      .datain  (1'b1),
      .dataout (valid_out[w])
    );

    l2_way_array #(.WIDTH(1)) u_dirty (
      .clk     (clk),
      .rst_n   (rst_n),
      .index   (index),
      .write   (way_we[w]),
      .datain  (ctrl.dirty_in),
      .dataout (dirty_out[w])
    );
  end

  // *************************************************************************
  // Hit detection and replacement.
  // *************************************************************************

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (way_hit[w])
        hit_way = l2_way_t'(w);
    end
  end

  l2_plru u_plru (
    .clk         (clk),
    .rst_n       (rst_n),
    .index       (index),
    .touch       (ctrl.lru_touch),
    .touched_way (hit_way),
    .victim      (victim)
  );

  assign status.hit          = |way_hit;
  assign status.victim_dirty = valid_out[victim] && dirty_out[victim];

  assign mem_rdata  = data_out[hit_way];
  assign pmem_wdata = data_out[victim];

  // Line aligned, tag from the request or from the evicted line.
  assign phys_tag     = (ctrl.addr_src == ADDR_VICTIM) ? tag_out[victim] : req_tag;
  assign pmem_address = {phys_tag, index, {OFFSET_W{1'b0}}};

  // A fill only ever lands in a set that missed.
  a_single_hit : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(way_hit));

endmodule : l2_cache_datapath

`default_nettype wire

/* hdl/l2_cache_control.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_cache_control
  import l2_cache_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic mem_read,
  input  wire logic mem_write,
  input  l2_status_t status,
  input  wire logic pmem_resp,
  output l2_ctrl_t   ctrl,
  output logic       mem_resp,
  output logic       pmem_read,
  output logic       pmem_write
);

  l2_state_e state;
  l2_state_e next_state;
  logic      request;

  assign request = mem_read || mem_write;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= S_CHECK;
    else
      state <= next_state;
  end

  // *************************************************************************
  // Next state and outputs.
  // *************************************************************************

  always_comb
  begin
    next_state     = state;
    ctrl.way_write = 1'b0;
    ctrl.fill      = 1'b0;
    ctrl.data_src  = SRC_PMEM;
    ctrl.dirty_in  = 1'b0;
    ctrl.lru_touch = 1'b0;
    ctrl.addr_src  = ADDR_REQUEST;
    mem_resp       = 1'b0;
    pmem_read      = 1'b0;
    pmem_write     = 1'b0;

    case (state)
      S_CHECK:
      begin
        if (request)
        begin
          if (status.hit)
          begin
            mem_resp       = 1'b1;
            ctrl.lru_touch = 1'b1;
            // Write hit stores the whole line.
            if (mem_write)
            begin
              ctrl.way_write = 1'b1;
              ctrl.data_src  = SRC_CPU;
              ctrl.dirty_in  = 1'b1;
            end
          end
          else if (status.victim_dirty)
          begin
            next_state = S_WRITEBACK;
          end
          else
          begin
            next_state = S_ALLOCATE;
          end
        end
      end

      S_WRITEBACK:
      begin
        pmem_write    = 1'b1;
        ctrl.addr_src = ADDR_VICTIM;
        if (pmem_resp)
          next_state = S_ALLOCATE;
      end

      S_ALLOCATE:
      begin
        pmem_read = 1'b1;
        if (pmem_resp)
        begin
          // Clean fill into the victim way.
          ctrl.way_write = 1'b1;
          ctrl.fill      = 1'b1;
          next_state     = S_CHECK;
        end
      end

      default:
      begin
        next_state = S_CHECK;
      end
    endcase
  end

  a_pmem_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(pmem_read && pmem_write));

  // The level above issues one kind of request at a time.
  a_mem_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write));

endmodule : l2_cache_control

`default_nettype wire

/* hdl/l2_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_cache
  import l2_cache_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  // Level above.
  input  wire logic mem_read,
  input  wire logic mem_write,
  input  lc3b_word  mem_address,
  input  l2_line_t  mem_wdata,
  output l2_line_t  mem_rdata,
  output logic      mem_resp,
  // Physical memory.
  output logic      pmem_read,
  output logic      pmem_write,
  output lc3b_word  pmem_address,
  output l2_line_t  pmem_wdata,
  input  l2_line_t  pmem_rdata,
  input  wire logic pmem_resp
);

  l2_ctrl_t   ctrl;
  l2_status_t status;

  l2_cache_control u_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .status     (status),
    .pmem_resp  (pmem_resp),
    .ctrl       (ctrl),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write)
  );

  l2_cache_datapath u_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .pmem_rdata   (pmem_rdata),
    .ctrl         (ctrl),
    .status       (status),
    .mem_rdata    (mem_rdata),
    .pmem_wdata   (pmem_wdata),
    .pmem_address (pmem_address)
  );

endmodule : l2_cache

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 4;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

/* sim/l2_cache_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_cache_checker
  import l2_cache_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     mem_read,
  input  wire logic     mem_write,
  input  wire lc3b_word mem_address,
  input  wire l2_line_t mem_wdata,
  input  wire l2_line_t mem_rdata,
  input  wire logic     mem_resp,
  input  wire logic     pmem_read,
  input  wire logic     pmem_write,
  input  wire lc3b_word pmem_address,
  input  wire l2_line_t pmem_wdata,
  input  wire logic     pmem_resp,
  output int            errors,
  output int            responses
);

  l2_tag_t   model_tag   [NUM_SETS][NUM_WAYS];
  logic      model_valid [NUM_SETS][NUM_WAYS];
  logic      model_dirty [NUM_SETS][NUM_WAYS];
  l2_lru_t   model_lru   [NUM_SETS];
  l2_line_t  latest      [lc3b_word];

  logic      active;
  logic      exp_hit;
  logic      exp_wb;
  l2_index_t req_set;
  l2_way_t   req_way;
  lc3b_word  req_line;
  lc3b_word  wb_line;
  int        reads_seen;
  int        writes_seen;
  int        busy_cycles;

  function automatic l2_line_t initial_line(lc3b_word addr);
    l2_line_t line;
    for (int i = 0; i < 8; i++)
      line[i*16 +: 16] = (addr + 16'(i * 4951)) ^ 16'hc35a;
    return line;
  endfunction

  function automatic l2_line_t latest_line(lc3b_word addr);
    if (latest.exists(addr))
      return latest[addr];
    return initial_line(addr);
  endfunction

  // b2 picks the pair and b1 or b0 the way inside it.
  function automatic l2_way_t pick_victim(l2_lru_t b);
    return {b[2], b[2] ? b[0] : b[1]};
  endfunction

  // Point the tree away from the way just used.
  function automatic l2_lru_t touch_lru(l2_lru_t b, l2_way_t way);
    l2_lru_t n;
    n    = b;
    n[2] = !way[1];
    if (!way[1])
      n[1] = !way[0];
    else
      n[0] = !way[0];
    return n;
  endfunction

  task automatic report_mismatch(string name, l2_line_t expected, l2_line_t actual);
    $display("mismatch %s expected %0h got %0h at %0t ns", name, expected, actual, $time);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("%s at %0t ns", what, $time);
    errors++;
  endtask

  task automatic reset_model();
    for (int s = 0; s < NUM_SETS; s++)
    begin
      model_lru[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        model_tag[s][w]   = '0;
        model_valid[s][w] = 1'b0;
        model_dirty[s][w] = 1'b0;
      end
    end
    latest.delete();
    active    = 1'b0;
    errors    = 0;
    responses = 0;
  endtask

  // ***************************************************************************
  // Prediction at request start.
  // ***************************************************************************

  task automatic start_request();
    req_set     = mem_address[6:4];
    req_line    = {mem_address[15:4], 4'h0};
    exp_hit     = 1'b0;
    exp_wb      = 1'b0;
    reads_seen  = 0;
    writes_seen = 0;
    busy_cycles = 0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (model_valid[req_set][w] && model_tag[req_set][w] == mem_address[15:7])
      begin
        exp_hit = 1'b1;
        req_way = l2_way_t'(w);
      end
    end
    if (!exp_hit)
    begin
      req_way = pick_victim(model_lru[req_set]);
      exp_wb  = model_valid[req_set][req_way] && model_dirty[req_set][req_way];
      wb_line = {model_tag[req_set][req_way], req_set, 4'h0};
    end
    active = 1'b1;
  endtask

  task automatic observe_memory();
    if (pmem_read || pmem_write)
      busy_cycles++;
    if (pmem_resp && pmem_write)
    begin
      writes_seen++;
      if (!exp_wb || reads_seen != 0)
        report_failure("write-back to memory where none was expected");
      else if (pmem_address != wb_line)
        report_mismatch("pmem_address", l2_line_t'(wb_line), l2_line_t'(pmem_address));
      else if (pmem_wdata != latest_line(wb_line))
        report_mismatch("pmem_wdata", latest_line(wb_line), pmem_wdata);
    end
    if (pmem_resp && pmem_read)
    begin
      reads_seen++;
      if (pmem_address != req_line)
        report_mismatch("pmem_address", l2_line_t'(req_line), l2_line_t'(pmem_address));
    end
  endtask

  task automatic finish_request();
    if (exp_hit && busy_cycles != 0)
      report_failure("memory traffic during a predicted hit");
    if (!exp_hit)
    begin
      if (reads_seen != 1)
        report_failure("miss did not read exactly one line from memory");
      if (writes_seen != (exp_wb ? 1 : 0))
        report_failure("write-back count does not match the victim state");
      model_tag[req_set][req_way]   = mem_address[15:7];
      model_valid[req_set][req_way] = 1'b1;
      model_dirty[req_set][req_way] = 1'b0;
    end
    if (mem_read && mem_rdata != latest_line(req_line))
      report_mismatch("mem_rdata", latest_line(req_line), mem_rdata);
    if (mem_write)
    begin
      model_dirty[req_set][req_way] = 1'b1;
      latest[req_line]              = mem_wdata;
    end
    model_lru[req_set] = touch_lru(model_lru[req_set], req_way);
    responses++;
    active = 1'b0;
  endtask

  // Sampled mid cycle away from both edges.
  always @(negedge clk)
  begin
    if (!rst_n)
      reset_model();
    else
    begin
      if (!active && (mem_read || mem_write))
        start_request();
      if (active)
      begin
        observe_memory();
        if (mem_resp)
          finish_request();
      end
      else if (mem_resp || pmem_read || pmem_write)
        report_failure("DUT active with no request pending");
    end
  end

endmodule : l2_cache_checker

`default_nettype wire

/* sim/l2_cache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module l2_cache_tb
  import l2_cache_pkg::*;
();

  localparam int NUM_REQUESTS   = 400;
  localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 40;

  // Six tags in each of four sets, more lines than ways.
  localparam l2_tag_t   TAGS [6] = '{9'h000, 9'h035, 9'h0a3, 9'h11e, 9'h16c, 9'h1f1};
  localparam l2_index_t SETS [4] = '{3'd0, 3'd2, 3'd5, 3'd7};

  logic     clk;
  logic     rst_n;
  logic     mem_read;
  logic     mem_write;
  lc3b_word mem_address;
  l2_line_t mem_wdata;
  l2_line_t mem_rdata;
  logic     mem_resp;
  logic     pmem_read;
  logic     pmem_write;
  lc3b_word pmem_address;
  l2_line_t pmem_wdata;
  l2_line_t pmem_rdata;
  logic     pmem_resp;
  int       errors;
  int       responses;
  int       seed = 80;

  l2_line_t line_store [lc3b_word];

  function automatic l2_line_t initial_line(lc3b_word addr);
    l2_line_t line;
    for (int i = 0; i < 8; i++)
      line[i*16 +: 16] = (addr + 16'(i * 4951)) ^ 16'hc35a;
    return line;
  endfunction

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  l2_cache u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_address (pmem_address),
    .pmem_wdata   (pmem_wdata),
    .pmem_rdata   (pmem_rdata),
    .pmem_resp    (pmem_resp)
  );

  l2_cache_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_address (pmem_address),
    .pmem_wdata   (pmem_wdata),
    .pmem_resp    (pmem_resp),
    .errors       (errors),
    .responses    (responses)
  );

  // ***************************************************************************
  // Physical memory, answers after 1 to 4 cycles.
  // ***************************************************************************

  initial
  begin : responder
    int       delay;
    lc3b_word addr;
    pmem_resp  = 1'b0;
    pmem_rdata = '0;
    forever
    begin
      @(negedge clk);
      if (rst_n && (pmem_read || pmem_write))
      begin
        delay = ($random(seed) & 3) + 1;
        addr  = pmem_address;
        if (pmem_write)
          line_store[addr] = pmem_wdata;
        repeat (delay) @(posedge clk);
        #1;
        if (!pmem_write)
          pmem_rdata = line_store.exists(addr) ? line_store[addr] : initial_line(addr);
        pmem_resp = 1'b1;
        @(posedge clk);
        #1;
        pmem_resp = 1'b0;
      end
    end
  end

  initial
  begin : stimulus
    int   r;
    int   tag_sel;
    logic is_write;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    mem_address = '0;
    mem_wdata   = '0;
    wait (rst_n);
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_REQUESTS; n++)
    begin
      r           = $random(seed);
      tag_sel     = int'(r[15:8]) % 6;
      is_write    = r[20];
      mem_address = {TAGS[tag_sel], SETS[r[1:0]], r[19:16]};
      mem_wdata   = {$random(seed), $random(seed), $random(seed), $random(seed)};
      mem_read    = !is_write;
      mem_write   = is_write;
      @(negedge clk);
      while (!mem_resp)
        @(negedge clk);
      @(posedge clk);
      #1;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      // Now and then an idle cycle.
      if (r[24])
      begin
        @(posedge clk);
        #1;
      end
    end
    repeat (4) @(posedge clk);
    $display("closing count: %0d errors, %0d of %0d responses checked",
             errors, responses, NUM_REQUESTS);
    if (errors == 0 && responses == NUM_REQUESTS)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout reached after %0d cycles with %0d responses", TIMEOUT_CYCLES, responses);
    $display("test failed");
    $finish;
  end

endmodule : l2_cache_tb

`default_nettype wire

/* sources.f */
hdl/l2_cache_pkg.sv
hdl/l2_way_array.sv
hdl/l2_plru.sv
hdl/l2_cache_datapath.sv
hdl/l2_cache_control.sv
hdl/l2_cache.sv
sim/tb_clock_gen.sv
sim/l2_cache_checker.sv
sim/l2_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module l2_cache_tb -f sources.f -o l2_cache_sim
./obj_dir/l2_cache_sim | tee sim.log

if grep -q "^test passed$" sim.log
then
  echo "simulation finished without errors"
  exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1
